/* source/vector_cfg_pkg.sv */
`default_nettype none

package vector_cfg_pkg;

    // --------------------
    // Datapath sizes
    // --------------------
    localparam int VLEN      = 64;
    localparam int VLENB     = VLEN / 8;     // One byte per element
    localparam int NUM_VREGS = 32;

    typedef logic [4:0]       vreg_addr_t;
    typedef logic [VLEN-1:0]  vdata_t;
    typedef logic [VLENB-1:0] byte_en_t;

    // Result packet, also the write-back request
    typedef struct packed {
        vreg_addr_t vd;
        vdata_t     data;       // Full new value of vd
        byte_en_t   byte_en;    // Bytes actually written
        logic       illegal;
    } wb_t;

endpackage

`default_nettype wire

/* source/vector_isa_pkg.sv */
`default_nettype none

package vector_isa_pkg;

    // --------------------
    // Encoding constants
    // --------------------
    localparam logic [6:0] OPCODE_VEC = 7'b1010111;

    localparam logic [2:0] FUNCT3_OPIVV = 3'b000;
    localparam logic [2:0] FUNCT3_OPMVV = 3'b010;
    localparam logic [2:0] FUNCT3_OPIVI = 3'b011;

    localparam logic [5:0] FUNCT6_VADD  = 6'b000000;   // Also vadd.vi
    localparam logic [5:0] FUNCT6_VSUB  = 6'b000010;
    localparam logic [5:0] FUNCT6_VAND  = 6'b001001;
    localparam logic [5:0] FUNCT6_VOR   = 6'b001010;
    localparam logic [5:0] FUNCT6_VXOR  = 6'b001011;
    localparam logic [5:0] FUNCT6_VMV   = 6'b010111;   // vmv.v.v when vm is set
    localparam logic [5:0] FUNCT6_VMUL  = 6'b100101;   // OPMVV
    localparam logic [5:0] FUNCT6_VMACC = 6'b101101;   // OPMVV

    // Bits 19..15 are a register or an immediate, by category
    typedef union packed {
        vector_cfg_pkg::vreg_addr_t vs1;
        logic signed [4:0]          simm5;
    } src1_u;

    typedef struct packed {
        logic [5:0]                 funct6;
        logic                       vm;
        vector_cfg_pkg::vreg_addr_t vs2;
        src1_u                      src1;
        logic [2:0]                 funct3;
        vector_cfg_pkg::vreg_addr_t vd;
        logic [6:0]                 opcode;
    } instr_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        MUL,
        MACC,
        MOVE,
        ILLEGAL
    } vop_e;

    // Decoded form, held in the decode register
    typedef struct packed {
        vop_e                       op;
        logic                       use_imm;
        logic [7:0]                 imm;        // simm5 sign-extended to a byte
        logic                       masked;     // Inverse of vm
        vector_cfg_pkg::vreg_addr_t vs1;
        vector_cfg_pkg::vreg_addr_t vs2;
        vector_cfg_pkg::vreg_addr_t vd;
    } dec_t;

endpackage

`default_nettype wire

/* source/vector_regbank.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_regbank (
    input  logic                       clk,
    input  logic                       reset_n,

    input  vector_cfg_pkg::vreg_addr_t vs1_addr,
    input  vector_cfg_pkg::vreg_addr_t vs2_addr,
    input  vector_cfg_pkg::vreg_addr_t vs3_addr,

    input  vector_cfg_pkg::byte_en_t   enable,
    input  vector_cfg_pkg::vreg_addr_t vd_addr,
    input  vector_cfg_pkg::vdata_t     result,

    output vector_cfg_pkg::vdata_t     v0_mask,
    output vector_cfg_pkg::vdata_t     vs1_data,
    output vector_cfg_pkg::vdata_t     vs2_data,
    output vector_cfg_pkg::vdata_t     vs3_data
);

    vector_cfg_pkg::vdata_t [vector_cfg_pkg::NUM_VREGS-1:0] regs;

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs <= '0;
        end else begin
            for (int b = 0; b < vector_cfg_pkg::VLENB; b++) begin
                if (enable[b]) begin
                    regs[vd_addr][8*b +: 8] <= result[8*b +: 8];   // Byte lane
                end
            end
        end
    end

    // --------------------
    // Read ports
    // --------------------
    assign vs1_data = regs[vs1_addr];
    assign vs2_data = regs[vs2_addr];
    assign vs3_data = regs[vs3_addr];

    // v0 lives in the array like any other register
    assign v0_mask  = regs[0];

    assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(enable));

endmodule

`default_nettype wire

/* source/vector_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_decode (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       instr_valid,
    input  vector_isa_pkg::instr_t     instr,
    output logic                       instr_ready,

    input  logic                       pend_valid,
    input  vector_cfg_pkg::wb_t        pend,

    output logic                       dec_valid,
    output vector_isa_pkg::dec_t       dec,
    input  logic                       dec_ready,

    output vector_cfg_pkg::vreg_addr_t vs1_addr,
    output vector_cfg_pkg::vreg_addr_t vs2_addr,
    output vector_cfg_pkg::vreg_addr_t vs3_addr
);

    vector_isa_pkg::dec_t dec_n;
    vector_isa_pkg::dec_t dec_q;
    logic                 full;
    logic                 hazard;

    // --------------------
    // Instruction decode
    // --------------------
    always_comb begin
        dec_n         = '0;
        dec_n.op      = vector_isa_pkg::ILLEGAL;
        dec_n.masked  = ~instr.vm;
        dec_n.vs1     = instr.src1.vs1;
        dec_n.vs2     = instr.vs2;
        dec_n.vd      = instr.vd;
        dec_n.imm     = {{3{instr.src1.simm5[4]}}, instr.src1.simm5};

        if (instr.opcode == vector_isa_pkg::OPCODE_VEC) begin
            case (instr.funct3)
                vector_isa_pkg::FUNCT3_OPIVV: begin
                    case (instr.funct6)
                        vector_isa_pkg::FUNCT6_VADD: dec_n.op = vector_isa_pkg::ADD;
                        vector_isa_pkg::FUNCT6_VSUB: dec_n.op = vector_isa_pkg::SUB;
                        vector_isa_pkg::FUNCT6_VAND: dec_n.op = vector_isa_pkg::AND;
                        vector_isa_pkg::FUNCT6_VOR:  dec_n.op = vector_isa_pkg::OR;
                        vector_isa_pkg::FUNCT6_VXOR: dec_n.op = vector_isa_pkg::XOR;
                        vector_isa_pkg::FUNCT6_VMV: begin
                            if (instr.vm) dec_n.op = vector_isa_pkg::MOVE;  // vmerge unsupported
                        end
                        default: ;
                    endcase
                end
                vector_isa_pkg::FUNCT3_OPIVI: begin
                    if (instr.funct6 == vector_isa_pkg::FUNCT6_VADD) begin
                        dec_n.op      = vector_isa_pkg::ADD;
                        dec_n.use_imm = 1'b1;
                    end
                end
                vector_isa_pkg::FUNCT3_OPMVV: begin
                    case (instr.funct6)
                        vector_isa_pkg::FUNCT6_VMUL:  dec_n.op = vector_isa_pkg::MUL;
                        vector_isa_pkg::FUNCT6_VMACC: dec_n.op = vector_isa_pkg::MACC;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // Hazard against the pending result
    // --------------------
    // An illegal result writes nothing, so it never blocks
    assign hazard = full && pend_valid && (|pend.byte_en) &&
                    ((pend.vd == dec_q.vs1) || (pend.vd == dec_q.vs2) ||
                     (pend.vd == dec_q.vd)  || (dec_q.masked && pend.vd == '0));

    assign dec_valid   = full & ~hazard;
    assign dec         = dec_q;
    assign instr_ready = ~full | (dec_valid & dec_ready);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full <= 1'b0;
        end else if (instr_ready) begin
            full <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            dec_q <= dec_n;
        end
    end

    // Read addresses come from the held entry
    assign vs1_addr = dec_q.vs1;
    assign vs2_addr = dec_q.vs2;
    assign vs3_addr = dec_q.vd;     // Old destination for merge and vmacc

    assert property (@(posedge clk) disable iff (!reset_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

`default_nettype wire

/* source/vector_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_execute (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       dec_valid,
    input  vector_isa_pkg::dec_t       dec,
    output logic                       dec_ready,

    input  vector_cfg_pkg::vdata_t     v0_mask,
    input  vector_cfg_pkg::vdata_t     vs1_data,
    input  vector_cfg_pkg::vdata_t     vs2_data,
    input  vector_cfg_pkg::vdata_t     vs3_data,

    output logic                       res_valid,
    output vector_cfg_pkg::wb_t        res,
    input  logic                       res_ready,

    output logic                       pend_valid,
    output vector_cfg_pkg::wb_t        pend,

    output vector_cfg_pkg::byte_en_t   wr_en,
    output vector_cfg_pkg::vreg_addr_t wr_addr,
    output vector_cfg_pkg::vdata_t     wr_data
);

    vector_cfg_pkg::byte_en_t byte_en_n;
    vector_cfg_pkg::vdata_t   data_n;
    vector_cfg_pkg::wb_t      wb_n;
    vector_cfg_pkg::wb_t      res_q;
    logic                     full;

    // --------------------
    // Byte enables
    // --------------------
    always_comb begin
        if (dec.op == vector_isa_pkg::ILLEGAL) begin
            byte_en_n = '0;
        end else if (dec.masked) begin
            byte_en_n = v0_mask[vector_cfg_pkg::VLENB-1:0];   // One mask bit per element
        end else begin
            byte_en_n = '1;
        end
    end

    // --------------------
    // Lane arithmetic
    // --------------------
    always_comb begin
        logic [7:0] op1;
        logic [7:0] op2;
        logic [7:0] old;
        logic [7:0] lane;

        for (int i = 0; i < vector_cfg_pkg::VLENB; i++) begin
            op1 = dec.use_imm ? dec.imm : vs1_data[8*i +: 8];
            op2 = vs2_data[8*i +: 8];
            old = vs3_data[8*i +: 8];
            case (dec.op)
                vector_isa_pkg::ADD:  lane = op2 + op1;
                vector_isa_pkg::SUB:  lane = op2 - op1;
                vector_isa_pkg::AND:  lane = op2 & op1;
                vector_isa_pkg::OR:   lane = op2 | op1;
                vector_isa_pkg::XOR:  lane = op2 ^ op1;
                vector_isa_pkg::MUL:  lane = op2 * op1;         // Low byte of product
                vector_isa_pkg::MACC: lane = old + op2 * op1;
                vector_isa_pkg::MOVE: lane = op1;
                default:              lane = old;
            endcase
            // Disabled bytes carry the old contents
            data_n[8*i +: 8] = byte_en_n[i] ? lane : old;
        end
    end

    always_comb begin
        wb_n         = '0;
        wb_n.vd      = dec.vd;
        wb_n.data    = data_n;
        wb_n.byte_en = byte_en_n;
        wb_n.illegal = (dec.op == vector_isa_pkg::ILLEGAL);
    end

    // --------------------
    // Result register
    // --------------------
    assign dec_ready = ~full | res_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full <= 1'b0;
        end else if (dec_ready) begin
            full <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            res_q <= wb_n;
        end
    end

    assign res_valid  = full;
    assign res        = res_q;
    assign pend_valid = full;
    assign pend       = res_q;

    // Bank write happens on the output handshake only
    assign wr_en   = (full && res_ready) ? res_q.byte_en : '0;
    assign wr_addr = res_q.vd;
    assign wr_data = res_q.data;

    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid && !res_ready |=> res_valid && $stable(res));

    assert property (@(posedge clk) disable iff (!reset_n)
        res_valid && res.illegal |-> res.byte_en == '0);

endmodule

`default_nettype wire

/* source/vector_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_unit (
    input  logic                   clk,
    input  logic                   reset_n,

    input  logic                   instr_valid,
    input  vector_isa_pkg::instr_t instr,
    output logic                   instr_ready,

    output logic                   res_valid,
    output vector_cfg_pkg::wb_t    res,
    input  logic                   res_ready
);

    // Decode to execute
    logic                       dec_valid;
    logic                       dec_ready;
    vector_isa_pkg::dec_t       dec;

    // Pending result seen by decode
    logic                       pend_valid;
    vector_cfg_pkg::wb_t        pend;

    // --------------------
    // Register bank ports
    // --------------------
    vector_cfg_pkg::vreg_addr_t vs1_addr;
    vector_cfg_pkg::vreg_addr_t vs2_addr;
    vector_cfg_pkg::vreg_addr_t vs3_addr;
    vector_cfg_pkg::vdata_t     v0_mask;
    vector_cfg_pkg::vdata_t     vs1_data;
    vector_cfg_pkg::vdata_t     vs2_data;
    vector_cfg_pkg::vdata_t     vs3_data;
    vector_cfg_pkg::byte_en_t   wr_en;
    vector_cfg_pkg::vreg_addr_t wr_addr;
    vector_cfg_pkg::vdata_t     wr_data;

    vector_decode u_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .pend_valid  (pend_valid),
        .pend        (pend),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .dec_ready   (dec_ready),
        .vs1_addr    (vs1_addr),
        .vs2_addr    (vs2_addr),
        .vs3_addr    (vs3_addr)
    );

    vector_regbank u_regbank (
        .clk      (clk),
        .reset_n  (reset_n),
        .vs1_addr (vs1_addr),
        .vs2_addr (vs2_addr),
        .vs3_addr (vs3_addr),
        .enable   (wr_en),
        .vd_addr  (wr_addr),
        .result   (wr_data),
        .v0_mask  (v0_mask),
        .vs1_data (vs1_data),
        .vs2_data (vs2_data),
        .vs3_data (vs3_data)
    );

    vector_execute u_execute (
        .clk        (clk),
        .reset_n    (reset_n),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dec_ready  (dec_ready),
        .v0_mask    (v0_mask),
        .vs1_data   (vs1_data),
        .vs2_data   (vs2_data),
        .vs3_data   (vs3_data),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready),
        .pend_valid (pend_valid),
        .pend       (pend),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

/* tb/tb_vector_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_unit;

    typedef logic [vector_cfg_pkg::NUM_VREGS-1:0][vector_cfg_pkg::VLEN-1:0] regfile_t;

    localparam int NUM_RANDOM = 300;

    logic                   clk;
    logic                   reset_n;
    logic                   instr_valid;
    vector_isa_pkg::instr_t instr;
    logic                   instr_ready;
    logic                   res_valid;
    vector_cfg_pkg::wb_t    res;
    logic                   res_ready;

    integer seed       = 20443;
    integer ready_seed = 20443;

    vector_isa_pkg::instr_t program_q[$];     // Whole instruction stream
    vector_isa_pkg::instr_t accepted_q[$];    // Accepted, result still owed
    regfile_t               model_rf;
    int                     checked = 0;

    vector_unit uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .res_valid   (res_valid),
        .res         (res),
        .res_ready   (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // --------------------
    // Instruction builders
    // --------------------
    function automatic vector_isa_pkg::instr_t vec_instr(
        input logic [5:0] f6,
        input logic [2:0] f3,
        input logic       vm,
        input logic [4:0] vd,
        input logic [4:0] vs2,
        input logic [4:0] src1
    );
        return {f6, vm, vs2, src1, f3, vd, vector_isa_pkg::OPCODE_VEC};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[5] ? {3'b000, r[1:0]} : r[4:0];   // Low registers often, for hazards
    endfunction

    function automatic vector_isa_pkg::instr_t random_instr();
        int                     kind;
        logic                   vm;
        logic [5:0]             f6;
        logic [2:0]             f3;
        logic [4:0]             vd;
        logic [4:0]             vs2;
        logic [4:0]             src1;
        vector_isa_pkg::instr_t ins;
        kind = $unsigned($random(seed)) % 11;
        vm   = ($unsigned($random(seed)) % 3) != 0;    // Masked one time in three
        vd   = pick_reg();
        vs2  = pick_reg();
        src1 = pick_reg();
        f3   = vector_isa_pkg::FUNCT3_OPIVV;
        case (kind)
            0: f6 = vector_isa_pkg::FUNCT6_VADD;
            1: f6 = vector_isa_pkg::FUNCT6_VSUB;
            2: f6 = vector_isa_pkg::FUNCT6_VAND;
            3: f6 = vector_isa_pkg::FUNCT6_VOR;
            4: f6 = vector_isa_pkg::FUNCT6_VXOR;
            5: begin
                f6 = vector_isa_pkg::FUNCT6_VMUL;
                f3 = vector_isa_pkg::FUNCT3_OPMVV;
            end
            6: begin
                f6 = vector_isa_pkg::FUNCT6_VMACC;
                f3 = vector_isa_pkg::FUNCT3_OPMVV;
            end
            7: begin
                f6   = vector_isa_pkg::FUNCT6_VADD;
                f3   = vector_isa_pkg::FUNCT3_OPIVI;
                src1 = 5'($random(seed));              // Any simm5
            end
            8: begin
                f6  = vector_isa_pkg::FUNCT6_VMV;
                vs2 = 5'd0;
            end
            9: f6 = 6'b111111;                          // Unknown funct6
            default: f6 = vector_isa_pkg::FUNCT6_VADD;
        endcase
        ins = vec_instr(f6, f3, vm, vd, vs2, src1);
        if (kind == 10) begin
            ins.opcode = 7'b0000111;                    // Vector load, not supported
        end
        return ins;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic vector_cfg_pkg::wb_t expected_result(
        input vector_isa_pkg::instr_t ins,
        input regfile_t               rf
    );
        vector_isa_pkg::vop_e op;
        logic                 use_imm;
        logic [7:0]           imm8;
        logic [7:0]           a;
        logic [7:0]           b;
        logic [7:0]           old;
        logic [4:0]           vs1;
        logic [4:0]           vs2;
        logic [4:0]           vd;
        int                   lane;
        vector_cfg_pkg::wb_t  want;
        vd      = ins[11:7];
        vs2     = ins[24:20];
        vs1     = ins[19:15];
        imm8    = {{3{ins[19]}}, ins[19:15]};
        use_imm = 1'b0;
        op      = vector_isa_pkg::ILLEGAL;

        if (ins[6:0] == vector_isa_pkg::OPCODE_VEC) begin
            if (ins[14:12] == vector_isa_pkg::FUNCT3_OPIVV) begin
                case (ins[31:26])
                    vector_isa_pkg::FUNCT6_VADD: op = vector_isa_pkg::ADD;
                    vector_isa_pkg::FUNCT6_VSUB: op = vector_isa_pkg::SUB;
                    vector_isa_pkg::FUNCT6_VAND: op = vector_isa_pkg::AND;
                    vector_isa_pkg::FUNCT6_VOR:  op = vector_isa_pkg::OR;
                    vector_isa_pkg::FUNCT6_VXOR: op = vector_isa_pkg::XOR;
                    vector_isa_pkg::FUNCT6_VMV: begin
                        if (ins[25]) begin
                            op = vector_isa_pkg::MOVE;     // vm clear means vmerge
                        end
                    end
                    default: ;
                endcase
            end else if (ins[14:12] == vector_isa_pkg::FUNCT3_OPIVI &&
                         ins[31:26] == vector_isa_pkg::FUNCT6_VADD) begin
                op      = vector_isa_pkg::ADD;
                use_imm = 1'b1;
            end else if (ins[14:12] == vector_isa_pkg::FUNCT3_OPMVV) begin
                if (ins[31:26] == vector_isa_pkg::FUNCT6_VMUL) begin
                    op = vector_isa_pkg::MUL;
                end else if (ins[31:26] == vector_isa_pkg::FUNCT6_VMACC) begin
                    op = vector_isa_pkg::MACC;
                end
            end
        end

        want         = '0;
        want.vd      = vd;
        want.illegal = (op == vector_isa_pkg::ILLEGAL);
        if (want.illegal) begin
            want.byte_en = '0;
        end else if (!ins[25]) begin
            want.byte_en = rf[0][vector_cfg_pkg::VLENB-1:0];   // One v0 bit per element
        end else begin
            want.byte_en = '1;
        end

        for (int i = 0; i < vector_cfg_pkg::VLENB; i++) begin
            a   = use_imm ? imm8 : rf[vs1][8*i +: 8];
            b   = rf[vs2][8*i +: 8];
            old = rf[vd][8*i +: 8];
            case (op)
                vector_isa_pkg::ADD:  lane = int'(b) + int'(a);
                vector_isa_pkg::SUB:  lane = int'(b) - int'(a);
                vector_isa_pkg::AND:  lane = int'(b & a);
                vector_isa_pkg::OR:   lane = int'(b | a);
                vector_isa_pkg::XOR:  lane = int'(b ^ a);
                vector_isa_pkg::MUL:  lane = int'(b) * int'(a);
                vector_isa_pkg::MACC: lane = int'(old) + int'(b) * int'(a);
                vector_isa_pkg::MOVE: lane = int'(a);
                default:              lane = int'(old);
            endcase
            want.data[8*i +: 8] = want.byte_en[i] ? 8'(lane & 255) : old;   // Modulo 256
        end
        return want;
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    initial begin : drive_instructions
        vector_isa_pkg::instr_t bad;
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;

        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VMV, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd3, 5'd0, 5'd9));     // Zero after reset
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VADD, vector_isa_pkg::FUNCT3_OPIVI,
                                      1'b1, 5'd1, 5'd0, 5'b10101)); // v1 = 0 + (-11)
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VMUL, vector_isa_pkg::FUNCT3_OPMVV,
                                      1'b1, 5'd2, 5'd1, 5'd1));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VADD, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd0, 5'd2, 5'd1));     // Mask pattern into v0
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VADD, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b0, 5'd4, 5'd1, 5'd2));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VMACC, vector_isa_pkg::FUNCT3_OPMVV,
                                      1'b0, 5'd4, 5'd2, 5'd1));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VADD, vector_isa_pkg::FUNCT3_OPIVI,
                                      1'b0, 5'd0, 5'd0, 5'd3));     // Masked write of v0 itself
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VSUB, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd5, 5'd4, 5'd1));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VAND, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd6, 5'd4, 5'd2));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VOR, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd7, 5'd6, 5'd1));
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VXOR, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd8, 5'd7, 5'd5));
        program_q.push_back(vec_instr(6'b111111, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd4, 5'd1, 5'd2));     // Unknown funct6
        bad        = vec_instr(vector_isa_pkg::FUNCT6_VADD, vector_isa_pkg::FUNCT3_OPIVV,
                               1'b1, 5'd4, 5'd1, 5'd2);
        bad.opcode = 7'b0000111;
        program_q.push_back(bad);
        program_q.push_back(vec_instr(vector_isa_pkg::FUNCT6_VMV, vector_isa_pkg::FUNCT3_OPIVV,
                                      1'b1, 5'd9, 5'd0, 5'd4));     // v4 must be unchanged
        for (int n = 0; n < NUM_RANDOM; n++) begin
            program_q.push_back(random_instr());
        end

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_value("reset instr_ready", 128'(1'b1), 128'(instr_ready));
        check_value("reset res_valid", 128'(1'b0), 128'(res_valid));

        for (int n = 0; n < program_q.size(); n++) begin
            if (($random(seed) & 7) == 0) begin
                instr_valid <= 1'b0;                        // Idle gap
                @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr       <= program_q[n];
            @(posedge clk);
            while (!instr_ready) begin
                @(posedge clk);
            end
            accepted_q.push_back(program_q[n]);
        end
        instr_valid <= 1'b0;
    end

    initial begin : toggle_res_ready
        res_ready = 1'b0;
        forever begin
            @(posedge clk);
            res_ready <= (($random(ready_seed) & 1) != 0);
        end
    end

    // --------------------
    // Result checking
    // --------------------
    initial begin : compare_results
        vector_isa_pkg::instr_t ins;
        vector_cfg_pkg::wb_t    want;
        vector_cfg_pkg::wb_t    held_res;
        logic                   held;
        held     = 1'b0;
        held_res = '0;
        model_rf = '0;                                      // Bank resets to zero
        forever begin
            @(posedge clk);
            if (reset_n) begin
                if (held) begin
                    check_value("held res_valid", 128'(1'b1), 128'(res_valid));
                    check_value("held res", 128'(held_res), 128'(res));
                end
                if (res_valid && res_ready) begin
                    if (accepted_q.size() == 0) begin
                        abort_run("A result arrived with no instruction outstanding");
                    end else begin
                        ins  = accepted_q.pop_front();
                        want = expected_result(ins, model_rf);
                        check_value($sformatf("result %0d vd", checked),
                                    128'(want.vd), 128'(res.vd));
                        check_value($sformatf("result %0d data", checked),
                                    128'(want.data), 128'(res.data));
                        check_value($sformatf("result %0d byte_en", checked),
                                    128'(want.byte_en), 128'(res.byte_en));
                        check_value($sformatf("result %0d illegal", checked),
                                    128'(want.illegal), 128'(res.illegal));
                        if (want.byte_en != '0) begin
                            model_rf[want.vd] = want.data;  // Old bytes already merged
                        end
                        checked++;
                    end
                end
                held     = res_valid && !res_ready;
                held_res = res;
            end
        end
    end

    initial begin : run_control
        int cycles;
        int limit;
        int total;
        cycles = 0;
        @(posedge clk);
        total = program_q.size();
        limit = 20 * total + 100;
        while (checked < total && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (checked == total) begin
            repeat (5) @(posedge clk);                      // Room for a stray extra result
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results checked",
                                cycles, checked, total));
        end
    end

endmodule

`default_nettype wire

/* flist.f */
source/vector_cfg_pkg.sv
source/vector_isa_pkg.sv
source/vector_regbank.sv
source/vector_decode.sv
source/vector_execute.sv
source/vector_unit.sv
tb/tb_vector_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the vector unit testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_vector_unit \
        -f flist.f \
        -o tb_vector_unit; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_vector_unit)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" <<< "$output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
